// File: include/core_defines.svh
`ifndef CORE_DEFINES_SVH
`define CORE_DEFINES_SVH

// datapath width and the RV32E register count
`define CORE_XLEN      32
`define CORE_NREGS     16

// depth of each credit link buffer and the credits a sender starts with
`define LINK_DEPTH     2

// CSR values seen right after reset
`define MSTATUS_RESET  32'h1800
`define MVENDORID_VAL  32'h79737978
`define MARCHID_VAL    32'h017DC685

`endif

// File: logic/core_pkg.sv
`default_nettype none
`include "core_defines.svh"

package core_pkg;

  typedef logic [3:0] reg_idx_t;

  typedef enum logic [11:0] {
    CSR_MSTATUS   = 12'h300,
    CSR_MTVEC     = 12'h305,
    CSR_MEPC      = 12'h341,
    CSR_MCAUSE    = 12'h342,
    CSR_MVENDORID = 12'hF11,
    CSR_MARCHID   = 12'hF12
  } csr_addr_e;

  typedef enum logic [3:0] {
    OP_NONE,                              // any encoding outside the kept set
    OP_ADD,
    OP_SUB,
    OP_ADDI,
    OP_LUI,
    OP_CSRRW,
    OP_CSRRS,
    OP_ECALL,
    OP_MRET
  } op_e;

  typedef struct packed {
    logic [`CORE_XLEN-1:0] instr;
    logic [`CORE_XLEN-1:0] pc;
  } raw_instr_t;

  typedef struct packed {
    op_e                   op;
    reg_idx_t              rd;            // zero when nothing is written back
    reg_idx_t              rs1;
    reg_idx_t              rs2;
    logic [`CORE_XLEN-1:0] imm;
    csr_addr_e             csr;
    logic [`CORE_XLEN-1:0] pc;
  } issue_t;

  typedef struct packed {
    op_e                   op;
    reg_idx_t              rd;
    logic [`CORE_XLEN-1:0] value;
    csr_addr_e             csr;
    logic [`CORE_XLEN-1:0] csr_wdata;
    logic                  csr_wen;
    logic [`CORE_XLEN-1:0] pc;
    logic [`CORE_XLEN-1:0] target;        // redirect pc for ECALL and MRET
  } exec_t;

endpackage

`default_nettype wire

// File: logic/core_ifs.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

interface rf_read_if;
  import core_pkg::*;

  reg_idx_t              rs1;
  reg_idx_t              rs2;
  csr_addr_e             csr_addr;
  logic [`CORE_XLEN-1:0] src1;
  logic [`CORE_XLEN-1:0] src2;
  logic [`CORE_XLEN-1:0] csr_data;

  modport master (output rs1, rs2, csr_addr, input src1, src2, csr_data);
  modport slave  (input rs1, rs2, csr_addr, output src1, src2, csr_data);
endinterface

interface rf_write_if;
  import core_pkg::*;

  logic                  wen;
  reg_idx_t              rd;
  logic [`CORE_XLEN-1:0] wdata;
  logic                  csr_wen;
  csr_addr_e             csr_addr;
  logic [`CORE_XLEN-1:0] csr_wdata;
  logic                  ecall;
  logic                  mret;
  logic [`CORE_XLEN-1:0] pc;

  modport master (output wen, rd, wdata, csr_wen, csr_addr, csr_wdata, ecall, mret, pc);
  modport slave  (input wen, rd, wdata, csr_wen, csr_addr, csr_wdata, ecall, mret, pc);
endinterface

`default_nettype wire

// File: logic/credit_fifo.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module credit_fifo #(
  parameter type payload_t = logic
) (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     push,
  input  payload_t push_data,
  input  logic     pop,
  output logic     head_valid,
  output payload_t head,
  output logic     credit
);
  localparam int DEPTH = `LINK_DEPTH;
  localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W = $clog2(DEPTH + 1);

  payload_t         mem [DEPTH];
  logic [PTR_W-1:0] wr_ptr;
  logic [PTR_W-1:0] rd_ptr;
  logic [CNT_W-1:0] count;
  logic             do_pop;

  assign head_valid = (count != '0);
  assign head       = mem[rd_ptr];
  assign do_pop     = pop && head_valid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
      credit <= 1'b0;
    end else begin
      if (push) wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      if (do_pop) rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      count  <= count + CNT_W'(push) - CNT_W'(do_pop);
      credit <= do_pop;                   // one credit back per slot freed
    end
  end

  always_ff @(posedge clk) begin
    if (push) mem[wr_ptr] <= push_data;
  end

  // a sender that keeps to its credits never finds this buffer full
  push_when_full: assert property (@(posedge clk) disable iff (!rst_n)
    push |-> count < CNT_W'(DEPTH));

endmodule

`default_nettype wire

// File: logic/decode_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module decode_unit (
  input  logic                 clk,
  input  logic                 rst_n,
  input  logic                 instr_valid,
  input  core_pkg::raw_instr_t instr,
  output logic                 instr_credit,
  output logic                 issue_valid,
  output core_pkg::issue_t     issue,
  input  logic                 issue_credit,
  input  logic                 retire_valid,
  input  core_pkg::reg_idx_t   retire_rd
);
  import core_pkg::*;

  localparam int CREDIT_W = $clog2(`LINK_DEPTH + 1);
  localparam int FLIGHT_W = 4;

  raw_instr_t             head;
  logic                   head_valid;
  logic [6:0]             opcode;
  logic [2:0]             funct3;
  logic [6:0]             funct7;
  logic [4:0]             f_rd;
  logic [4:0]             f_rs1;
  logic [4:0]             f_rs2;
  logic                   csr_ok;
  logic                   i_ok;
  logic                   r_ok;
  issue_t                 dec;
  logic                   is_sys;
  logic                   hazard;
  logic                   fire;
  logic [CREDIT_W-1:0]    credit_cnt;
  logic [`CORE_NREGS-1:0] busy;
  logic                   sys_busy;
  logic [FLIGHT_W-1:0]    inflight;

  credit_fifo #(.payload_t(raw_instr_t)) in_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (instr_valid),
    .push_data  (instr),
    .pop        (fire),
    .head_valid (head_valid),
    .head       (head),
    .credit     (instr_credit)
  );

  assign opcode = head.instr[6:0];
  assign f_rd   = head.instr[11:7];
  assign funct3 = head.instr[14:12];
  assign f_rs1  = head.instr[19:15];
  assign f_rs2  = head.instr[24:20];
  assign funct7 = head.instr[31:25];
  assign i_ok   = !f_rd[4] && !f_rs1[4];  // RV32E has no x16 and up
  assign r_ok   = i_ok && !f_rs2[4];

  always_comb begin
    case (head.instr[31:20])
      CSR_MSTATUS, CSR_MTVEC, CSR_MEPC, CSR_MCAUSE, CSR_MVENDORID, CSR_MARCHID: csr_ok = 1'b1;
      default: csr_ok = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // instruction decode

  always_comb begin
    dec.op  = OP_NONE;
    dec.rd  = '0;
    dec.rs1 = '0;
    dec.rs2 = '0;
    dec.imm = '0;
    dec.csr = CSR_MSTATUS;
    dec.pc  = head.pc;
    is_sys  = 1'b0;
    case (opcode)
      7'b0110011: begin
        if (r_ok && funct3 == 3'b000 && funct7 == 7'b0000000) dec.op = OP_ADD;
        else if (r_ok && funct3 == 3'b000 && funct7 == 7'b0100000) dec.op = OP_SUB;
      end
      7'b0010011: if (i_ok && funct3 == 3'b000) dec.op = OP_ADDI;
      7'b0110111: if (!f_rd[4]) dec.op = OP_LUI;
      7'b1110011: begin
        if (i_ok && csr_ok && funct3 == 3'b001) dec.op = OP_CSRRW;
        else if (i_ok && csr_ok && funct3 == 3'b010) dec.op = OP_CSRRS;
        else if (head.instr == 32'h0000_0073) dec.op = OP_ECALL;
        else if (head.instr == 32'h3020_0073) dec.op = OP_MRET;
      end
      default: ;
    endcase
    case (dec.op)
      OP_ADD, OP_SUB: begin
        dec.rd  = f_rd[3:0];
        dec.rs1 = f_rs1[3:0];
        dec.rs2 = f_rs2[3:0];
      end
      OP_ADDI: begin
        dec.rd  = f_rd[3:0];
        dec.rs1 = f_rs1[3:0];
        dec.imm = {{20{head.instr[31]}}, head.instr[31:20]};
      end
      OP_LUI: begin
        dec.rd  = f_rd[3:0];
        dec.imm = {head.instr[31:12], 12'b0};
      end
      OP_CSRRW, OP_CSRRS: begin
        dec.rd  = f_rd[3:0];
        dec.rs1 = f_rs1[3:0];
        dec.csr = csr_addr_e'(head.instr[31:20]);
        is_sys  = 1'b1;
      end
      OP_ECALL: begin
        dec.csr = CSR_MTVEC;              // trap target comes back as the csr read
        is_sys  = 1'b1;
      end
      OP_MRET: begin
        dec.csr = CSR_MEPC;
        is_sys  = 1'b1;
      end
      default: ;
    endcase
  end

  //////////////////////////////////////////////////
  // hazards and issue

  // unused source fields are x0, whose busy bit is never set
  assign hazard = busy[dec.rs1] || busy[dec.rs2] || busy[dec.rd] || sys_busy ||
                  (is_sys && inflight != '0);
  assign fire   = head_valid && credit_cnt != '0 && !hazard;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      issue_valid <= 1'b0;
      credit_cnt  <= CREDIT_W'(`LINK_DEPTH);
      busy        <= '0;
      sys_busy    <= 1'b0;
      inflight    <= '0;
    end else begin
      issue_valid <= fire;
      credit_cnt  <= credit_cnt - CREDIT_W'(fire) + CREDIT_W'(issue_credit);
      if (retire_valid) busy[retire_rd] <= 1'b0;
      if (fire && dec.rd != '0) busy[dec.rd] <= 1'b1;
      if (retire_valid) sys_busy <= 1'b0;
      if (fire && is_sys) sys_busy <= 1'b1;  // it issues alone, so the next retire is its own
      inflight <= inflight + FLIGHT_W'(fire) - FLIGHT_W'(retire_valid);
    end
  end

  always_ff @(posedge clk) begin
    if (fire) issue <= dec;
  end

  credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
    credit_cnt <= CREDIT_W'(`LINK_DEPTH));

  flight_underflow: assert property (@(posedge clk) disable iff (!rst_n)
    retire_valid |-> inflight != '0);

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module reg_file (
  input logic       clk,
  input logic       rst_n,
  rf_read_if.slave  rd_port,
  rf_write_if.slave wr_port
);
  import core_pkg::*;

  localparam logic [`CORE_XLEN-1:0] TRAP_MSTATUS = 32'h1800;  // MPP set to machine mode
  localparam logic [`CORE_XLEN-1:0] CAUSE_ECALL  = 32'd11;

  logic [`CORE_XLEN-1:0] gpr [1:`CORE_NREGS-1];
  logic [`CORE_XLEN-1:0] mstatus;
  logic [`CORE_XLEN-1:0] mtvec;
  logic [`CORE_XLEN-1:0] mepc;
  logic [`CORE_XLEN-1:0] mcause;
  logic [`CORE_XLEN-1:0] mret_status;

  //////////////////////////////////////////////////
  // read side

  assign rd_port.src1 = (rd_port.rs1 == '0) ? '0 : gpr[rd_port.rs1];
  assign rd_port.src2 = (rd_port.rs2 == '0) ? '0 : gpr[rd_port.rs2];

  always_comb begin
    case (rd_port.csr_addr)
      CSR_MSTATUS:   rd_port.csr_data = mstatus;
      CSR_MTVEC:     rd_port.csr_data = mtvec;
      CSR_MEPC:      rd_port.csr_data = mepc;
      CSR_MCAUSE:    rd_port.csr_data = mcause;
      CSR_MVENDORID: rd_port.csr_data = `MVENDORID_VAL;
      CSR_MARCHID:   rd_port.csr_data = `MARCHID_VAL;
      default:       rd_port.csr_data = '0;
    endcase
  end

  //////////////////////////////////////////////////
  // write side

  // MIE takes MPIE, MPIE goes to 1 and MPP is cleared
  always_comb begin
    mret_status        = mstatus;
    mret_status[3]     = mstatus[7];
    mret_status[7]     = 1'b1;
    mret_status[12:11] = 2'b00;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 1; i < `CORE_NREGS; i++) begin
        gpr[i] <= '0;
      end
      mstatus <= `MSTATUS_RESET;
      mtvec   <= '0;
      mepc    <= '0;
      mcause  <= '0;
    end else begin
      if (wr_port.wen && wr_port.rd != '0) gpr[wr_port.rd] <= wr_port.wdata;
      if (wr_port.ecall) begin
        mepc    <= wr_port.pc;
        mcause  <= CAUSE_ECALL;
        mstatus <= TRAP_MSTATUS;
      end else if (wr_port.mret) begin
        mstatus <= mret_status;
      end else if (wr_port.csr_wen) begin
        case (wr_port.csr_addr)
          CSR_MSTATUS: mstatus <= wr_port.csr_wdata;
          CSR_MTVEC:   mtvec   <= wr_port.csr_wdata;
          CSR_MEPC:    mepc    <= wr_port.csr_wdata;
          CSR_MCAUSE:  mcause  <= wr_port.csr_wdata;
          default: ;                      // the id registers are read-only
        endcase
      end
    end
  end

  trap_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
    !(wr_port.ecall && wr_port.mret));

endmodule

`default_nettype wire

// File: logic/execute_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module execute_unit (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             issue_valid,
  input  core_pkg::issue_t issue,
  output logic             issue_credit,
  rf_read_if.master        rd_port,
  output logic             exec_valid,
  output core_pkg::exec_t  exec,
  input  logic             exec_credit
);
  import core_pkg::*;

  localparam int CREDIT_W = $clog2(`LINK_DEPTH + 1);

  issue_t              head;
  logic                head_valid;
  logic                fire;
  logic [CREDIT_W-1:0] credit_cnt;
  exec_t               res;

  credit_fifo #(.payload_t(issue_t)) issue_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (issue_valid),
    .push_data  (issue),
    .pop        (fire),
    .head_valid (head_valid),
    .head       (head),
    .credit     (issue_credit)
  );

  assign rd_port.rs1      = head.rs1;
  assign rd_port.rs2      = head.rs2;
  assign rd_port.csr_addr = head.csr;

  assign fire = head_valid && credit_cnt != '0;

  //////////////////////////////////////////////////
  // ALU and CSR values

  always_comb begin
    res.op        = head.op;
    res.rd        = head.rd;
    res.value     = '0;
    res.csr       = head.csr;
    res.csr_wdata = '0;
    res.csr_wen   = 1'b0;
    res.pc        = head.pc;
    res.target    = '0;
    case (head.op)
      OP_ADD:  res.value = rd_port.src1 + rd_port.src2;
      OP_SUB:  res.value = rd_port.src1 - rd_port.src2;
      OP_ADDI: res.value = rd_port.src1 + head.imm;
      OP_LUI:  res.value = head.imm;
      OP_CSRRW: begin
        res.value     = rd_port.csr_data;   // rd gets the old csr value
        res.csr_wdata = rd_port.src1;
        res.csr_wen   = 1'b1;
      end
      OP_CSRRS: begin
        res.value     = rd_port.csr_data;
        res.csr_wdata = rd_port.csr_data | rd_port.src1;
        res.csr_wen   = (head.rs1 != '0);   // csrrs with x0 is a pure read
      end
      OP_ECALL, OP_MRET: res.target = rd_port.csr_data;
      default: ;
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      exec_valid <= 1'b0;
      credit_cnt <= CREDIT_W'(`LINK_DEPTH);
    end else begin
      exec_valid <= fire;
      credit_cnt <= credit_cnt - CREDIT_W'(fire) + CREDIT_W'(exec_credit);
    end
  end

  always_ff @(posedge clk) begin
    if (fire) exec <= res;
  end

endmodule

`default_nettype wire

// File: logic/result_unit.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module result_unit (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  exec_valid,
  input  core_pkg::exec_t       exec,
  output logic                  exec_credit,
  rf_write_if.master            wr_port,
  output logic                  result_valid,
  output core_pkg::reg_idx_t    result_rd,
  output logic [`CORE_XLEN-1:0] result_data,
  output logic [`CORE_XLEN-1:0] result_pc,
  output logic                  redirect_valid,
  output logic [`CORE_XLEN-1:0] redirect_pc
);
  import core_pkg::*;

  exec_t head;
  logic  head_valid;

  // the retire stream is never stalled, so the head drains every cycle
  credit_fifo #(.payload_t(exec_t)) exec_fifo (
    .clk        (clk),
    .rst_n      (rst_n),
    .push       (exec_valid),
    .push_data  (exec),
    .pop        (head_valid),
    .head_valid (head_valid),
    .head       (head),
    .credit     (exec_credit)
  );

  assign wr_port.wen       = head_valid && head.rd != '0;
  assign wr_port.rd        = head.rd;
  assign wr_port.wdata     = head.value;
  assign wr_port.csr_wen   = head_valid && head.csr_wen;
  assign wr_port.csr_addr  = head.csr;
  assign wr_port.csr_wdata = head.csr_wdata;
  assign wr_port.ecall     = head_valid && head.op == OP_ECALL;
  assign wr_port.mret      = head_valid && head.op == OP_MRET;
  assign wr_port.pc        = head.pc;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      result_valid   <= 1'b0;
      redirect_valid <= 1'b0;
    end else begin
      result_valid   <= head_valid;
      redirect_valid <= wr_port.ecall || wr_port.mret;
    end
  end

  always_ff @(posedge clk) begin
    if (head_valid) begin
      result_rd   <= head.rd;
      result_data <= head.value;
      result_pc   <= head.pc;
      redirect_pc <= head.target;
    end
  end

endmodule

`default_nettype wire

// File: logic/core_top.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module core_top (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  instr_valid,
  input  logic [`CORE_XLEN-1:0] instr,
  input  logic [`CORE_XLEN-1:0] instr_pc,
  output logic                  instr_credit,
  output logic                  result_valid,
  output core_pkg::reg_idx_t    result_rd,
  output logic [`CORE_XLEN-1:0] result_data,
  output logic [`CORE_XLEN-1:0] result_pc,
  output logic                  redirect_valid,
  output logic [`CORE_XLEN-1:0] redirect_pc
);
  import core_pkg::*;

  logic   issue_valid;
  issue_t issue;
  logic   issue_credit;
  logic   exec_valid;
  exec_t  exec;
  logic   exec_credit;

  rf_read_if  rd_bus ();
  rf_write_if wr_bus ();

  decode_unit decode_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .instr_valid  (instr_valid),
    .instr        ({instr, instr_pc}),     // packs into raw_instr_t
    .instr_credit (instr_credit),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .issue_credit (issue_credit),
    .retire_valid (result_valid),
    .retire_rd    (result_rd)
  );

  execute_unit execute_inst (
    .clk          (clk),
    .rst_n        (rst_n),
    .issue_valid  (issue_valid),
    .issue        (issue),
    .issue_credit (issue_credit),
    .rd_port      (rd_bus),
    .exec_valid   (exec_valid),
    .exec         (exec),
    .exec_credit  (exec_credit)
  );

  result_unit result_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .exec_valid     (exec_valid),
    .exec           (exec),
    .exec_credit    (exec_credit),
    .wr_port        (wr_bus),
    .result_valid   (result_valid),
    .result_rd      (result_rd),
    .result_data    (result_data),
    .result_pc      (result_pc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  reg_file reg_file_inst (
    .clk     (clk),
    .rst_n   (rst_n),
    .rd_port (rd_bus),
    .wr_port (wr_bus)
  );

endmodule

`default_nettype wire

// File: test/core_checker.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module core_checker (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               instr_valid,
  input  logic [31:0]        instr,
  input  logic [31:0]        instr_pc,
  input  logic               result_valid,
  input  core_pkg::reg_idx_t result_rd,
  input  logic [31:0]        result_data,
  input  logic [31:0]        result_pc,
  input  logic               redirect_valid,
  input  logic [31:0]        redirect_pc,
  output int                 retired
);
  import core_pkg::*;

  typedef struct packed {
    logic [3:0]  rd;
    logic [31:0] data;
    logic        data_ok;                 // traps carry no result value
    logic [31:0] pc;
    logic        redirect;
    logic [31:0] target;
    logic [3:0]  test;
  } expect_t;

  expect_t     exp_q [$];
  logic [31:0] regs [16];
  logic [31:0] mstatus;
  logic [31:0] mtvec;
  logic [31:0] mepc;
  logic [31:0] mcause;
  int          cur_test;
  int          num_tests;
  int          error_count;
  string       test_names [16];
  int          test_retired [16];
  int          test_errors [16];

  //////////////////////////////////////////////////
  // reference model

  function automatic logic [31:0] csr_value(input logic [11:0] addr);
    case (addr)
      CSR_MSTATUS:   csr_value = mstatus;
      CSR_MTVEC:     csr_value = mtvec;
      CSR_MEPC:      csr_value = mepc;
      CSR_MCAUSE:    csr_value = mcause;
      CSR_MVENDORID: csr_value = `MVENDORID_VAL;
      CSR_MARCHID:   csr_value = `MARCHID_VAL;
      default:       csr_value = '0;
    endcase
  endfunction

  function automatic void csr_store(input logic [11:0] addr, input logic [31:0] val);
    case (addr)
      CSR_MSTATUS: mstatus = val;
      CSR_MTVEC:   mtvec = val;
      CSR_MEPC:    mepc = val;
      CSR_MCAUSE:  mcause = val;
      default: ;                          // id registers keep their constants
    endcase
  endfunction

  function automatic expect_t ref_step(input logic [31:0] word, input logic [31:0] pc);
    expect_t     e;
    logic [31:0] a;
    logic [31:0] b;
    logic [11:0] csr;
    logic [31:0] old;
    a   = regs[word[18:15]];
    b   = regs[word[23:20]];
    csr = word[31:20];
    old = csr_value(csr);
    e         = '0;
    e.rd      = word[10:7];
    e.pc      = pc;
    e.data_ok = 1'b1;
    e.test    = 4'(cur_test);
    if (word[6:0] == 7'b0110011) begin
      e.data = word[30] ? a - b : a + b;
    end else if (word[6:0] == 7'b0010011) begin
      e.data = a + {{20{word[31]}}, word[31:20]};
    end else if (word[6:0] == 7'b0110111) begin
      e.data = {word[31:12], 12'h000};
    end else if (word == 32'h0000_0073) begin
      e.rd       = '0;
      e.data_ok  = 1'b0;
      e.redirect = 1'b1;
      e.target   = mtvec;
      mepc       = pc;
      mcause     = 32'd11;
      mstatus    = 32'h1800;
    end else if (word == 32'h3020_0073) begin
      e.rd       = '0;
      e.data_ok  = 1'b0;
      e.redirect = 1'b1;
      e.target   = mepc;
      mstatus    = {mstatus[31:13], 2'b00, mstatus[10:8], 1'b1, mstatus[6:4], mstatus[7],
                    mstatus[2:0]};
    end else begin                        // the stimulus sends only csrrw and csrrs here
      e.data = old;
      if (word[14:12] == 3'b001) csr_store(csr, a);
      else if (word[18:15] != 4'd0) csr_store(csr, old | a);
    end
    if (e.rd != 4'd0) regs[e.rd] = e.data;
    return e;
  endfunction

  //////////////////////////////////////////////////
  // comparison and reporting

  task automatic mismatch(input expect_t e, input string field, input logic [31:0] want,
                          input logic [31:0] got);
    $display("CHECK FAILED %s pc %08h %s expected %08h actual %08h",
             test_names[e.test], e.pc, field, want, got);
    error_count++;
    test_errors[e.test]++;
  endtask

  always @(posedge clk) begin
    expect_t e;
    if (!rst_n) begin
      for (int i = 0; i < 16; i++) regs[i] = '0;
      mstatus = `MSTATUS_RESET;
      mtvec   = '0;
      mepc    = '0;
      mcause  = '0;
      retired <= 0;
    end else begin
      if (instr_valid) exp_q.push_back(ref_step(instr, instr_pc));
      if (result_valid) begin
        retired <= retired + 1;
        if (exp_q.size() == 0) begin
          $display("unexpected retire of pc %08h with nothing outstanding", result_pc);
          error_count++;
        end else begin
          e = exp_q.pop_front();
          test_retired[e.test]++;
          if (result_rd !== e.rd) mismatch(e, "rd", 32'(e.rd), 32'(result_rd));
          if (e.data_ok && result_data !== e.data) mismatch(e, "data", e.data, result_data);
          if (result_pc !== e.pc) mismatch(e, "pc", e.pc, result_pc);
          if (redirect_valid !== e.redirect)
            mismatch(e, "redirect", 32'(e.redirect), 32'(redirect_valid));
          else if (e.redirect && redirect_pc !== e.target)
            mismatch(e, "target", e.target, redirect_pc);
        end
      end
    end
  end

  task automatic start_test(input string name);
    cur_test = num_tests;
    test_names[cur_test] = name;
    num_tests++;
  endtask

  task automatic end_test();
    $display("test %-12s %0d retired, %0d errors", test_names[cur_test],
             test_retired[cur_test], test_errors[cur_test]);
  endtask

  task automatic final_report(output int fails);
    if (exp_q.size() != 0) begin
      $display("%0d accepted instructions never retired", exp_q.size());
      error_count += exp_q.size();
    end
    $display("summary: %0d tests, %0d retired, %0d errors", num_tests, retired, error_count);
    fails = error_count;
  endtask

endmodule

`default_nettype wire

// File: test/core_tb.sv
`timescale 1ns/1ns
`default_nettype none
`include "core_defines.svh"

module core_tb;
  import core_pkg::*;

  localparam logic [31:0] ECALL_WORD = 32'h0000_0073;
  localparam logic [31:0] MRET_WORD  = 32'h3020_0073;
  localparam logic [2:0]  CSRRW      = 3'b001;
  localparam logic [2:0]  CSRRS      = 3'b010;

  logic        clk;
  logic        rst_n;
  logic        instr_valid;
  logic [31:0] instr;
  logic [31:0] instr_pc;
  logic        instr_credit;
  logic        result_valid;
  reg_idx_t    result_rd;
  logic [31:0] result_data;
  logic [31:0] result_pc;
  logic        redirect_valid;
  logic [31:0] redirect_pc;
  int          retired;
  int          credits;
  int          sent;
  int          cycles;
  int          fails;
  logic [31:0] next_pc;

  core_top core_top_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .instr_pc       (instr_pc),
    .instr_credit   (instr_credit),
    .result_valid   (result_valid),
    .result_rd      (result_rd),
    .result_data    (result_data),
    .result_pc      (result_pc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc)
  );

  core_checker check_inst (
    .clk            (clk),
    .rst_n          (rst_n),
    .instr_valid    (instr_valid),
    .instr          (instr),
    .instr_pc       (instr_pc),
    .result_valid   (result_valid),
    .result_rd      (result_rd),
    .result_data    (result_data),
    .result_pc      (result_pc),
    .redirect_valid (redirect_valid),
    .redirect_pc    (redirect_pc),
    .retired        (retired)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  //////////////////////////////////////////////////
  // instruction words

  function automatic logic [31:0] r_type(input logic [6:0] f7, input int rd, input int rs1,
                                         input int rs2);
    r_type = {f7, 5'(rs2), 5'(rs1), 3'b000, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] addi_word(input int rd, input int rs1, input logic [11:0] imm);
    addi_word = {imm, 5'(rs1), 3'b000, 5'(rd), 7'b0010011};
  endfunction

  function automatic logic [31:0] lui_word(input int rd, input logic [19:0] imm);
    lui_word = {imm, 5'(rd), 7'b0110111};
  endfunction

  function automatic logic [31:0] csr_word(input logic [2:0] f3, input int rd,
                                           input logic [11:0] csr, input int rs1);
    csr_word = {csr, 5'(rs1), f3, 5'(rd), 7'b1110011};
  endfunction

  // few registers so that most instructions depend on a recent one
  function automatic logic [31:0] random_alu();
    int rd;
    int rs1;
    int rs2;
    rd  = $urandom % 6;
    rs1 = $urandom % 6;
    rs2 = $urandom % 6;
    case ($urandom % 4)
      0: random_alu = r_type(7'h00, rd, rs1, rs2);
      1: random_alu = r_type(7'h20, rd, rs1, rs2);
      2: random_alu = addi_word(rd, rs1, 12'($urandom));
      default: random_alu = lui_word(rd, 20'($urandom));
    endcase
  endfunction

  //////////////////////////////////////////////////
  // credit link driver

  task automatic idle_cycle();
    @(posedge clk);
    if (instr_credit) credits++;
    instr_valid <= 1'b0;
  endtask

  task automatic send(input logic [31:0] word);
    logic done;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      if (instr_credit) credits++;
      if (credits > 0) begin
        instr_valid <= 1'b1;
        instr       <= word;
        instr_pc    <= next_pc;
        next_pc     = next_pc + 32'd4;
        credits--;
        sent++;
        done = 1'b1;
      end else begin
        instr_valid <= 1'b0;                // out of credit, wait for a pop
      end
    end
  endtask

  task automatic finish_test();
    while (retired < sent) idle_cycle();
    repeat (4) idle_cycle();              // room for a stray retire to show up
    check_inst.end_test();
  endtask

  initial begin
    cycles = 0;
    while (cycles < 20 * sent + 100) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout after %0d cycles with %0d sent and %0d retired", cycles, sent, retired);
    $display(">>> FAIL");
    $finish;
  end

  initial begin
    void'($urandom(32'h5b8d));
    rst_n       = 1'b0;
    instr_valid = 1'b0;
    instr       = '0;
    instr_pc    = '0;
    credits     = `LINK_DEPTH;
    sent        = 0;
    next_pc     = 32'h0000_1000;
    repeat (10) @(posedge clk);
    rst_n <= 1'b1;

    check_inst.start_test("alu_burst");
    send(addi_word(0, 0, 12'h7ff));       // x0 must stay zero
    send(r_type(7'h00, 1, 0, 0));
    repeat (40) send(random_alu());
    finish_test();

    check_inst.start_test("csr_rw");
    send(addi_word(1, 0, 12'h123));
    send(csr_word(CSRRW, 2, CSR_MTVEC, 1));
    send(csr_word(CSRRS, 3, CSR_MTVEC, 0));
    send(addi_word(4, 0, 12'h040));
    send(csr_word(CSRRS, 5, CSR_MTVEC, 4));
    send(csr_word(CSRRS, 6, CSR_MTVEC, 0));
    send(csr_word(CSRRW, 7, CSR_MEPC, 1));
    send(csr_word(CSRRS, 8, CSR_MEPC, 0));
    send(csr_word(CSRRS, 9, CSR_MSTATUS, 4));
    send(csr_word(CSRRS, 10, CSR_MSTATUS, 0));
    send(csr_word(CSRRW, 11, CSR_MCAUSE, 4));
    send(csr_word(CSRRS, 12, CSR_MCAUSE, 0));
    finish_test();

    check_inst.start_test("csr_ids");
    send(addi_word(2, 0, 12'hfff));
    send(csr_word(CSRRW, 3, CSR_MVENDORID, 2));
    send(csr_word(CSRRS, 4, CSR_MVENDORID, 0));
    send(csr_word(CSRRS, 5, CSR_MARCHID, 2));
    send(csr_word(CSRRS, 6, CSR_MARCHID, 0));
    finish_test();

    check_inst.start_test("ecall");
    send(lui_word(1, 20'h80000));
    send(csr_word(CSRRW, 0, CSR_MTVEC, 1));
    send(ECALL_WORD);
    send(csr_word(CSRRS, 2, CSR_MEPC, 0));
    send(csr_word(CSRRS, 3, CSR_MCAUSE, 0));
    send(csr_word(CSRRS, 4, CSR_MSTATUS, 0));
    finish_test();

    check_inst.start_test("mret");
    send(lui_word(1, 20'h00001));
    send(addi_word(1, 1, 12'h7ff));
    send(addi_word(1, 1, 12'h081));       // mstatus image 0x1880
    send(csr_word(CSRRW, 0, CSR_MSTATUS, 1));
    send(addi_word(2, 0, 12'h200));
    send(csr_word(CSRRW, 0, CSR_MEPC, 2));
    send(MRET_WORD);
    send(csr_word(CSRRS, 3, CSR_MSTATUS, 0));
    send(csr_word(CSRRW, 0, CSR_MSTATUS, 0));
    send(MRET_WORD);
    send(csr_word(CSRRS, 4, CSR_MSTATUS, 0));
    finish_test();

    check_inst.start_test("random_gaps");
    repeat (40) begin
      repeat ($urandom % 4) idle_cycle();
      if ($urandom % 8 == 0) send(csr_word(CSRRS, $urandom % 6, CSR_MTVEC, 0));
      else send(random_alu());
    end
    finish_test();

    check_inst.final_report(fails);
    if (fails == 0) $display(">>> PASS");
    else $display(">>> FAIL");
    $finish;
  end

endmodule

`default_nettype wire

// File: flist.f
+incdir+include
logic/core_pkg.sv
logic/core_ifs.sv
logic/credit_fifo.sv
logic/decode_unit.sv
logic/reg_file.sv
logic/execute_unit.sv
logic/result_unit.sv
logic/core_top.sv
test/core_checker.sv
test/core_tb.sv

// File: Bender.yml
package:
  name: rv32e_exec_path

export_include_dirs:
  - include

sources:
  - files:
      - logic/core_pkg.sv
      - logic/core_ifs.sv
      - logic/credit_fifo.sv
      - logic/decode_unit.sv
      - logic/reg_file.sv
      - logic/execute_unit.sv
      - logic/result_unit.sv
      - logic/core_top.sv
  - target: test
    files:
      - test/core_checker.sv
      - test/core_tb.sv
